// File: list.f
hw/alu_pkg.sv
hw/board_pkg.sv
hw/alu.sv
hw/key_debounce.sv
hw/entry_fsm.sv
hw/hex_display.sv
hw/alu_board.sv
tb/tb_alu_board.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the alu board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f list.f --top-module tb_alu_board -o sim_alu_board \
   > build.log 2>&1 \
   && ./obj_dir/sim_alu_board > sim.log 2>&1 \
   || { cat build.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: tb/tb_alu_board.sv
// ==========================================================
// alu board testbench
// directed tests on switches and keys, result read back from
// the seven-segment digits and checked against an alu model
// ==========================================================

module tb_alu_board;

   localparam int num_presses   = 66;
   localparam int watchdog_time = (num_presses * 24 + 200) * 4;

   // active-low digit patterns 0..f, bit 0 = segment a
   localparam logic [6:0] font_tab [16] = '{
      7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
      7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
      7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
      7'b0100111, 7'b0100001, 7'b0000110, 7'b0001110
   };

   logic             clk;
   logic             arst_n;
   logic [3:0]       key;
   logic [17:0]      sw;
   logic [6:0]       hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
   logic [16:0]      ledr;
   logic [3:0]       ledg;
   logic [7:0][6:0]  hex_all;
   integer           seed;
   int               errors;
   int               tests_run;
   int               tests_failed;

   alu_board #(.debounce_cycles(8)) dut0
   (
      .CLOCK_50 (clk),
      .arst_n   (arst_n),
      .KEY      (key),
      .SW       (sw),
      .HEX0     (hex0),
      .HEX1     (hex1),
      .HEX2     (hex2),
      .HEX3     (hex3),
      .HEX4     (hex4),
      .HEX5     (hex5),
      .HEX6     (hex6),
      .HEX7     (hex7),
      .LEDR     (ledr),
      .LEDG     (ledg)
   );

   assign hex_all = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};

   always #2 clk = ~clk;

   initial
   begin
      #(watchdog_time);
      $display("watchdog: tests did not finish in time");
      $display("Simulation FAILED");
      $finish;
   end

   function automatic logic [31:0] sext(input logic sign, input logic [15:0] value);
      return {{16{sign}}, value};
   endfunction

   // {ok, word}; ok drops on a pattern that is no hex digit
   function automatic logic [32:0] decode_display(input logic [7:0][6:0] segs);
      logic [31:0] word;
      logic        ok;
      logic        found;
      word = 32'd0;
      ok   = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         found = 1'b0;
         for (int j = 0; j < 16; j++)
         begin
            if (segs[i] == font_tab[j])
            begin
               word[i*4 +: 4] = 4'(j);
               found          = 1'b1;
            end
         end
         ok = ok & found;
      end
      return {ok, word};
   endfunction

   // reference model, returns {res, v, n, z}
   function automatic logic [34:0] model_alu(input logic [31:0] a, input logic [31:0] b,
                                             input logic [3:0] op);
      logic [31:0] res;
      logic        v;
      longint      wide;
      v = 1'b0;
      case (op)
         alu_pkg::op_add:
         begin
            res  = a + b;
            wide = longint'($signed(a)) + longint'($signed(b));
            v    = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
         end
         alu_pkg::op_sub:
         begin
            res  = a - b;
            wide = longint'($signed(a)) - longint'($signed(b));
            v    = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
         end
         alu_pkg::op_and:  res = a & b;
         alu_pkg::op_or:   res = a | b;
         alu_pkg::op_xor:  res = a ^ b;
         alu_pkg::op_nor:  res = ~(a | b);
         alu_pkg::op_sll:  res = a << b[4:0];
         alu_pkg::op_srl:  res = a >> b[4:0];
         alu_pkg::op_sra:  res = $unsigned($signed(a) >>> b[4:0]);
         alu_pkg::op_slt:  res = {31'd0, $signed(a) < $signed(b)};
         alu_pkg::op_sltu: res = {31'd0, a < b};
         default:          res = 32'd0;
      endcase
      return {res, v, res[31], res == 32'd0};
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic hold_key(input int k, input int low_cycles);
      @(negedge clk);
      key[k] = 1'b0;
      repeat (low_cycles) @(negedge clk);
      key[k] = 1'b1;
      repeat (12) @(negedge clk);
   endtask

   task automatic press_key(input int k);
      hold_key(k, 12);
   endtask

   task automatic load_operand(input logic sel, input logic sign, input logic [15:0] value);
      @(negedge clk);
      sw = {sel, sign, value};
      press_key(board_pkg::key_load);
   endtask

   task automatic wait_valid();
      int n;
      n = 0;
      while (!ledg[3] && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      assert (ledg[3])
      else
      begin
         $display("result_valid did not rise within 20 cycles of exec");
         errors++;
      end
   endtask

   task automatic check_display(input string name, input logic [31:0] exp);
      logic [32:0] shown;
      shown = decode_display(hex_all);
      assert (shown[32])
      else
      begin
         $display("%s: a digit shows a pattern that is no hex digit", name);
         errors++;
      end
      check_eq(name, shown[31:0], exp);
   endtask

   task automatic run_op(input logic a_sign, input logic [15:0] a_val,
                         input logic b_sign, input logic [15:0] b_val, input logic [3:0] op);
      logic [34:0] exp;
      exp = model_alu(sext(a_sign, a_val), sext(b_sign, b_val), op);
      load_operand(1'b1, a_sign, a_val);
      load_operand(1'b0, b_sign, b_val);
      @(negedge clk);
      sw = {14'd0, op};
      press_key(board_pkg::key_exec);
      wait_valid();
      check_display($sformatf("HEX op %0d", op), exp[34:3]);
      check_eq($sformatf("LEDG[2:0] op %0d", op), 32'(ledg[2:0]), 32'(exp[2:0]));
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before)
         $display("%s: ok", name);
      else
      begin
         $display("%s: %0d errors", name, errors - errs_before);
         tests_failed++;
      end
   endtask

   task automatic test_reset();
      int e0;
      e0 = errors;
      check_display("HEX", 32'd0);
      check_eq("LEDG", 32'(ledg), 32'd0);
      check_eq("LEDR", 32'(ledr), 32'd0);
      report_test("reset state", e0);
   endtask

   task automatic test_entry();
      int          e0;
      logic [15:0] va;
      logic [15:0] vb;
      e0 = errors;
      va = 16'($random(seed));
      vb = 16'($random(seed));
      @(negedge clk);
      sw = {14'd0, alu_pkg::op_add};
      press_key(board_pkg::key_exec);  // result valid first, so the load has to drop it
      wait_valid();
      load_operand(1'b1, 1'b1, va);
      check_eq("LEDR", 32'(ledr), 32'({1'b1, va}));
      check_eq("LEDG[3]", 32'(ledg[3]), 32'd0);
      load_operand(1'b0, 1'b0, vb);
      check_eq("LEDR", 32'(ledr), 32'({1'b0, vb}));
      check_eq("LEDG[3]", 32'(ledg[3]), 32'd0);
      report_test("operand entry", e0);
   endtask

   task automatic test_arith();
      int e0;
      e0 = errors;
      run_op(1'b0, 16'h1234, 1'b1, 16'h0010, alu_pkg::op_add);
      run_op(1'b0, 16'h0005, 1'b0, 16'h0005, alu_pkg::op_sub);  // zero
      run_op(1'b1, 16'h8000, 1'b1, 16'h8000, alu_pkg::op_add);  // negative, no overflow
      run_op(1'b0, 16'h8000, 1'b1, 16'h0000, alu_pkg::op_sub);
      run_op(1'($random(seed)), 16'($random(seed)), 1'($random(seed)), 16'($random(seed)),
             alu_pkg::op_add);
      run_op(1'($random(seed)), 16'($random(seed)), 1'($random(seed)), 16'($random(seed)),
             alu_pkg::op_sub);
      report_test("arithmetic and flags", e0);
   endtask

   task automatic test_all_ops();
      int         e0;
      logic [3:0] code;
      e0 = errors;
      for (int op = 0; op < 12; op++)
      begin
         code = (op == 11) ? 4'hc : 4'(op);  // last one is an unused code
         run_op(1'($random(seed)), 16'($random(seed)), 1'($random(seed)),
                16'($random(seed)), code);
      end
      report_test("all opcodes", e0);
   endtask

   task automatic test_debounce();
      int e0;
      e0 = errors;
      run_op(1'b0, 16'h1234, 1'b0, 16'h0001, alu_pkg::op_add);
      @(negedge clk);
      sw = {1'b1, 1'b0, 16'hbeef};
      hold_key(board_pkg::key_load, 5);  // too short to count
      check_eq("LEDR", 32'(ledr), 32'h00001);
      check_eq("LEDG[3]", 32'(ledg[3]), 32'd1);
      load_operand(1'b0, 1'b0, 16'h0002);
      @(negedge clk);
      sw = {14'd0, alu_pkg::op_add};
      key[board_pkg::key_exec] = 1'b0;
      repeat (20) @(negedge clk);
      sw = {14'd0, alu_pkg::op_sub};  // a second strobe would pick this up
      repeat (40) @(negedge clk);
      key[board_pkg::key_exec] = 1'b1;
      repeat (12) @(negedge clk);
      check_display("HEX", 32'h00001236);
      check_eq("LEDG[3]", 32'(ledg[3]), 32'd1);
      report_test("debounce", e0);
   endtask

   task automatic test_clear();
      int e0;
      e0 = errors;
      press_key(board_pkg::key_clear);
      check_display("HEX", 32'd0);
      check_eq("LEDG", 32'(ledg), 32'd0);
      report_test("clear", e0);
   endtask

   initial
   begin
      clk          = 1'b0;
      arst_n       = 1'b0;
      key          = 4'hf;
      sw           = 18'd0;
      seed         = 32'h9181f92c;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      test_reset();
      test_entry();
      test_arith();
      test_all_ops();
      test_debounce();
      test_clear();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: hw/alu_board.sv
// ==========================================================
// alu board
// DE2 top level: debounced keys, operand console, alu core
// and hex readout on the board pins
// ==========================================================

module alu_board
#(
   parameter int debounce_cycles = 250000  // 5 ms at 50 MHz
)
(
   input  logic                CLOCK_50,
   input  logic                arst_n,
   input  logic [3:0]          KEY,
   input  board_pkg::sw_word_u SW,
   output board_pkg::seg_t     HEX0,
   output board_pkg::seg_t     HEX1,
   output board_pkg::seg_t     HEX2,
   output board_pkg::seg_t     HEX3,
   output board_pkg::seg_t     HEX4,
   output board_pkg::seg_t     HEX5,
   output board_pkg::seg_t     HEX6,
   output board_pkg::seg_t     HEX7,
   output logic [16:0]         LEDR,
   output logic [3:0]          LEDG
);

   logic [3:0]            press;
   alu_pkg::word_t        op_a;
   alu_pkg::word_t        op_b;
   alu_pkg::alu_op_t      opcode;
   alu_pkg::alu_out_t     alu_out;
   alu_pkg::alu_out_t     result;
   logic                  result_valid;
   logic                  last_a;
   logic [15:0]           echo;
   board_pkg::seg_t [7:0] hex;

   key_debounce #(.debounce_cycles(debounce_cycles), .num_keys(4)) debounce0
   (
      .CLOCK_50 (CLOCK_50),
      .arst_n   (arst_n),
      .key_n    (KEY),
      .press    (press)
   );

   entry_fsm console0
   (
      .CLOCK_50     (CLOCK_50),
      .arst_n       (arst_n),
      .sw           (SW),
      .press        (press),
      .alu_out      (alu_out),
      .op_a         (op_a),
      .op_b         (op_b),
      .opcode       (opcode),
      .result       (result),
      .result_valid (result_valid),
      .last_a       (last_a),
      .echo         (echo)
   );

   alu alu0
   (
      .op_a   (op_a),
      .op_b   (op_b),
      .opcode (opcode),
      .out    (alu_out)
   );

   hex_display display0
   (
      .value (result.res),
      .hex   (hex)
   );

   assign {HEX7, HEX6, HEX5, HEX4, HEX3, HEX2, HEX1, HEX0} = hex;

   assign LEDR = {last_a, echo};
   assign LEDG = {result_valid, result.flags.v, result.flags.n, result.flags.z};

endmodule

// File: hw/hex_display.sv
// ==========================================================
// hex display
// splits a 32-bit word into eight nibbles and drives one
// active-low seven-segment digit per nibble
// ==========================================================

module hex_display
(
   input  alu_pkg::word_t          value,
   output board_pkg::seg_t [7:0]   hex
);

   function automatic board_pkg::seg_t font(input logic [3:0] nib);
      case (nib)
         4'h0: font = 7'b1000000;
         4'h1: font = 7'b1111001;
         4'h2: font = 7'b0100100;
         4'h3: font = 7'b0110000;
         4'h4: font = 7'b0011001;
         4'h5: font = 7'b0010010;
         4'h6: font = 7'b0000010;
         4'h7: font = 7'b1111000;
         4'h8: font = 7'b0000000;
         4'h9: font = 7'b0010000;
         4'ha: font = 7'b0001000;
         4'hb: font = 7'b0000011;
         4'hc: font = 7'b0100111;
         4'hd: font = 7'b0100001;
         4'he: font = 7'b0000110;
         default: font = 7'b0001110;  // f
      endcase
   endfunction

   // digit 0 is the low nibble
   always_comb
   begin
      for (int i = 0; i < 8; i++)
         hex[i] = font(value[i*4 +: 4]);
   end

endmodule

// File: hw/entry_fsm.sv
// ==========================================================
// entry fsm
// operator console: loads operands from the switches, runs
// the alu on an opcode and holds the registered result
// ==========================================================

module entry_fsm
(
   input  logic                 CLOCK_50,
   input  logic                 arst_n,
   input  board_pkg::sw_word_u  sw,
   input  logic [3:0]           press,
   input  alu_pkg::alu_out_t    alu_out,
   output alu_pkg::word_t       op_a,
   output alu_pkg::word_t       op_b,
   output alu_pkg::alu_op_t     opcode,
   output alu_pkg::alu_out_t    result,
   output logic                 result_valid,
   output logic                 last_a,
   output logic [15:0]          echo
);

   typedef enum logic [1:0] {s_idle, s_exec, s_show} state_t;

   state_t           state, state_d;
   alu_pkg::alu_op_t opcode_q;
   logic             do_clear;
   logic             do_load;
   logic             do_exec;

   // clear beats load beats exec
   assign do_clear = press[board_pkg::key_clear];
   assign do_load  = press[board_pkg::key_load] & ~do_clear;
   assign do_exec  = press[board_pkg::key_exec] & ~do_clear & ~do_load;

   // opcode follows the switches during the exec strobe
   assign opcode = do_exec ? sw.cmd.opcode : opcode_q;

   always_comb
   begin
      state_d = state;
      if (do_clear || do_load)
         state_d = s_idle;
      else if (do_exec)
         state_d = s_exec;
      else if (state == s_exec)
         state_d = s_show;
   end

   always_ff @(posedge CLOCK_50 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state        <= s_idle;
         opcode_q     <= alu_pkg::op_add;
         op_a         <= '0;
         op_b         <= '0;
         result       <= '0;
         result_valid <= 1'b0;
         last_a       <= 1'b0;
         echo         <= '0;
      end
      else
      begin
         state <= state_d;
         if (do_clear)
         begin
            opcode_q     <= alu_pkg::op_add;
            op_a         <= '0;
            op_b         <= '0;
            result       <= '0;
            result_valid <= 1'b0;
            last_a       <= 1'b0;
            echo         <= '0;
         end
         else if (do_load)
         begin
            if (sw.entry.sel)
               op_a <= {{16{sw.entry.sign}}, sw.entry.value};
            else
               op_b <= {{16{sw.entry.sign}}, sw.entry.value};
            last_a       <= sw.entry.sel;
            echo         <= sw.entry.value;
            result_valid <= 1'b0;  // operands changed, result is stale
         end
         else if (state_d == s_exec)
         begin
            opcode_q     <= opcode;
            result       <= alu_out;
            result_valid <= 1'b1;
         end
      end
   end

endmodule

// File: hw/key_debounce.sv
// ==========================================================
// key debounce
// per-key stability timer, turns bouncing active-low buttons
// into one-cycle press strobes
// ==========================================================

module key_debounce
#(
   parameter int debounce_cycles = 250000,
   parameter int num_keys        = 4
)
(
   input  logic                CLOCK_50,
   input  logic                arst_n,
   input  logic [num_keys-1:0] key_n,
   output logic [num_keys-1:0] press
);

   localparam int cnt_w = $clog2(debounce_cycles + 1);

   logic [cnt_w-1:0]    cnt [num_keys];
   logic [num_keys-1:0] stable_n;  // accepted level, 1 = released

   always_ff @(posedge CLOCK_50 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         stable_n <= '1;
         press    <= '0;
         for (int i = 0; i < num_keys; i++)
            cnt[i] <= '0;
      end
      else
      begin
         press <= '0;
         for (int i = 0; i < num_keys; i++)
         begin
            if (key_n[i] != stable_n[i])
            begin
               if (cnt[i] == cnt_w'(debounce_cycles - 1))
               begin
                  stable_n[i] <= key_n[i];
                  cnt[i]      <= '0;
                  press[i]    <= ~key_n[i];  // strobe on press only
               end
               else
                  cnt[i] <= cnt[i] + 1'b1;
            end
            else
               cnt[i] <= '0;  // bounce back, start over
         end
      end
   end

endmodule

// File: hw/alu.sv
// ==========================================================
// alu
// combinational 32-bit arithmetic and logic unit with zero,
// negative and signed overflow flags
// ==========================================================

module alu
(
   input  alu_pkg::word_t   op_a,
   input  alu_pkg::word_t   op_b,
   input  alu_pkg::alu_op_t opcode,
   output alu_pkg::alu_out_t out
);

   alu_pkg::word_t sum;
   alu_pkg::word_t diff;
   logic [4:0]     shamt;
   logic           v_add;
   logic           v_sub;

   assign sum   = op_a + op_b;
   assign diff  = op_a - op_b;
   assign shamt = op_b[4:0];

   // same-sign inputs, result sign differs
   assign v_add = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
   assign v_sub = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);

   always_comb
   begin
      out.flags.v = 1'b0;
      case (opcode)
         alu_pkg::op_add:
         begin
            out.res     = sum;
            out.flags.v = v_add;
         end
         alu_pkg::op_sub:
         begin
            out.res     = diff;
            out.flags.v = v_sub;
         end
         alu_pkg::op_and:  out.res = op_a & op_b;
         alu_pkg::op_or:   out.res = op_a | op_b;
         alu_pkg::op_xor:  out.res = op_a ^ op_b;
         alu_pkg::op_nor:  out.res = ~(op_a | op_b);
         alu_pkg::op_sll:  out.res = op_a << shamt;
         alu_pkg::op_srl:  out.res = op_a >> shamt;
         alu_pkg::op_sra:  out.res = $signed(op_a) >>> shamt;
         alu_pkg::op_slt:  out.res = {31'd0, $signed(op_a) < $signed(op_b)};
         alu_pkg::op_sltu: out.res = {31'd0, op_a < op_b};
         default:          out.res = '0;  // unassigned codes
      endcase
      out.flags.n = out.res[31];
      out.flags.z = (out.res == '0);
   end

endmodule

// File: hw/board_pkg.sv
// ==========================================================
// board types
// switch word views, pushbutton roles and the seven-segment
// digit for the DE2 console
// ==========================================================

package board_pkg;

   // SW[17] selects the target, SW[16] is the sign
   typedef struct packed
   {
      logic        sel;    // 1 = operand a
      logic        sign;
      logic [15:0] value;
   } sw_entry_t;

   typedef struct packed
   {
      logic [13:0]       unused;
      alu_pkg::alu_op_t  opcode;  // SW[3:0]
   } sw_cmd_t;

   typedef union packed
   {
      sw_entry_t entry;
      sw_cmd_t   cmd;
   } sw_word_u;

   // key 3 is spare
   typedef enum int
   {
      key_load  = 0,
      key_exec  = 1,
      key_clear = 2
   } key_idx;

   typedef logic [6:0] seg_t;  // active low, bit 0 = segment a

endpackage

// File: hw/alu_pkg.sv
// ==========================================================
// alu types
// opcode set, status flags and the combined result word of
// the 32-bit arithmetic core
// ==========================================================

package alu_pkg;

   typedef logic [31:0] word_t;

   // codes 11..15 are unassigned and give zero
   typedef enum logic [3:0]
   {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_and  = 4'd2,
      op_or   = 4'd3,
      op_xor  = 4'd4,
      op_nor  = 4'd5,
      op_sll  = 4'd6,
      op_srl  = 4'd7,
      op_sra  = 4'd8,
      op_slt  = 4'd9,
      op_sltu = 4'd10
   } alu_op_t;

   typedef struct packed
   {
      logic v;  // signed overflow, add/sub only
      logic n;
      logic z;
   } alu_flags_t;

   typedef struct packed
   {
      word_t      res;
      alu_flags_t flags;
   } alu_out_t;

endpackage
